//--- Makefile
# Verilator build of the state keeper testbench
VERILATOR ?= verilator
TOP       ?= tb_state_list
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a failing run fails the target
run: compile
	$(SIM_BIN) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/sat_ref.svh
// Reference model of decision, backtrack level and backtrack clear.
// Included inside the testbench module; needs NV and WL declared first.
`ifndef SAT_REF_SVH
`define SAT_REF_SVH

// lowest free variable gets VAL_FALSE at cur + 1; idx is -1 if none free
function automatic void ref_decide(input sat_pkg::val_t vals [NV],
                                   input logic [WL-1:0] cur,
                                   output int idx, output logic [WL-1:0] new_lvl);
    idx = -1;
    new_lvl = cur;
    for (int k = NV - 1; k >= 0; k--) begin
        if (vals[k] == sat_pkg::VAL_FREE) begin
            idx = k;
        end
    end
    if (idx >= 0) begin
        new_lvl = cur + 1'b1;
    end
endfunction

// highest conflicting level minus one, never below the base level
function automatic logic [WL-1:0] ref_bkt_lvl(input logic [WL-1:0] lvls [NV],
                                              input logic [NV-1:0] conf,
                                              input logic [WL-1:0] base);
    int hi;
    hi = 0;
    for (int k = 0; k < NV; k++) begin
        if (conf[k] && int'(lvls[k]) > hi) begin
            hi = int'(lvls[k]);
        end
    end
    if (hi - 1 < int'(base)) begin
        return base;
    end
    return WL'(hi - 1);
endfunction

// one variable: freed when assigned above the backtrack level
function automatic void ref_bkt_clear(inout sat_pkg::val_t val, inout logic [WL-1:0] lvl,
                                      input logic [WL-1:0] bkt);
    if (lvl > bkt) begin
        val = sat_pkg::VAL_FREE;
        lvl = '0;
    end
endfunction

`endif

//--- dv/tb_state_list.sv
// Testbench of the state keeper with 8 variables and 8-bit levels.
// Random stimulus, fixed seed; results are checked at falling edges.
`timescale 1ns/10ps

module tb_state_list;
    import sat_pkg::*;

    localparam int NV = 8;
    localparam int WL = 8;
    localparam int NUM_TESTS = 12;
    localparam int WATCHDOG_CYCLES = (NUM_TESTS + 2) * 200;

    `include "sat_ref.svh"

    logic clk, rst, start_decision_i, load_lvl_en_i, apply_imply_i, apply_analyze_i;
    logic apply_bkt_i, base_lvl_en_i;
    logic [WL-1:0] load_lvl_i, base_lvl_i;
    logic [NV-1:0] imply_wr_i, imply_true_i;
    val_t [NV-1:0] var_value_o;
    logic [NV*WL-1:0] var_lvl_o;
    logic [WL-1:0] cur_lvl_o, bkt_lvl_o;
    logic done_decision_o, done_imply_o, find_conflict_o, add_learntc_en_o;
    logic done_analyze_o, done_bkt_o;
    logic [NV-1:0] conflict_mask_o;

    // tracking model
    val_t model_val [NV];
    logic [WL-1:0] model_lvl [NV];
    logic [WL-1:0] model_cur, model_base, exp_bkt;
    logic [NV-1:0] model_conf;
    int seed = 44702;
    int errors = 0;
    int checks = 0;
    int add_cnt = 0;

    state_list #(.NUM_VARS(NV), .WIDTH_LVL(WL)) state_list_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_val(input string name, input val_t got, input val_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_lvl(input string name, input logic [WL-1:0] got, input logic [WL-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_state();
        for (int k = 0; k < NV; k++) begin
            check_val($sformatf("var_value_o[%0d]", k), var_value_o[k], model_val[k]);
            check_lvl($sformatf("var_lvl_o[%0d]", k), var_lvl_o[k*WL +: WL], model_lvl[k]);
            check_bit($sformatf("conflict_mask_o[%0d]", k), conflict_mask_o[k], model_conf[k]);
        end
        check_lvl("cur_lvl_o", cur_lvl_o, model_cur);
        check_bit("find_conflict_o", find_conflict_o, |model_conf);
    endtask

    // comparing process
    always @(negedge clk) begin
        if (rst) begin
            if (done_decision_o || done_imply_o || done_bkt_o) begin
                compare_state();
            end
            if (add_learntc_en_o) begin
                add_cnt++;
            end
            if (done_analyze_o) begin
                check_lvl("bkt_lvl_o", bkt_lvl_o, exp_bkt);
                if (add_cnt != 1) begin
                    errors++;
                    $display("expected one add_learntc_en_o pulse before done_analyze_o, saw %0d",
                             add_cnt);
                end
                add_cnt = 0;
            end
        end
    end

    // called at a falling edge; 0 decision, 1 imply, 2 analyze, 3 backtrack
    task automatic wait_done(input int which);
        bit seen;
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 50) begin
            case (which)
                0: seen = done_decision_o;
                1: seen = done_imply_o;
                2: seen = done_analyze_o;
                default: seen = done_bkt_o;
            endcase
            if (!seen) begin
                @(negedge clk);
                n++;
            end
        end
        if (!seen) begin
            errors++;
            $display("done pulse of kind %0d never came within 50 cycles", which);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        for (int k = 0; k < NV; k++) begin
            model_val[k] = VAL_FREE;
            model_lvl[k] = '0;
        end
        model_cur = '0;
        model_base = '0;
        model_conf = '0;
    endtask

    task automatic do_decide();
        int idx;
        logic [WL-1:0] nl;
        ref_decide(model_val, model_cur, idx, nl);
        start_decision_i = 1'b1;
        @(posedge clk);
        if (idx >= 0) begin
            model_val[idx] = VAL_FALSE;
            model_lvl[idx] = nl;
            model_cur = nl;
        end
        @(negedge clk);
        start_decision_i = 1'b0;
        wait_done(0);
    endtask

    task automatic do_imply(input logic [NV-1:0] mask, input logic [NV-1:0] vals);
        val_t v;
        imply_wr_i = mask;
        imply_true_i = vals;
        apply_imply_i = 1'b1;
        @(posedge clk);
        for (int k = 0; k < NV; k++) begin
            v = vals[k] ? VAL_TRUE : VAL_FALSE;
            if (mask[k] && model_val[k] == VAL_FREE) begin
                model_val[k] = v;
                model_lvl[k] = model_cur;
            end else if (mask[k] && model_val[k] != v) begin
                model_conf[k] = 1'b1;
            end
        end
        @(negedge clk);
        imply_wr_i = '0;
        wait_done(1);
        apply_imply_i = 1'b0;
    endtask

    task automatic do_analyze_backtrack();
        int r;
        r = $random(seed);
        model_base = WL'($unsigned(r) % (int'(model_cur) + 1));
        base_lvl_i = model_base;
        base_lvl_en_i = 1'b1;
        @(negedge clk);
        base_lvl_en_i = 1'b0;
        exp_bkt = ref_bkt_lvl(model_lvl, model_conf, model_base);
        apply_analyze_i = 1'b1;
        @(negedge clk);
        wait_done(2);
        apply_analyze_i = 1'b0;
        repeat (2) @(negedge clk);
        apply_bkt_i = 1'b1;
        @(posedge clk);
        for (int k = 0; k < NV; k++) begin
            ref_bkt_clear(model_val[k], model_lvl[k], exp_bkt);
        end
        model_conf = '0;
        model_cur = exp_bkt;
        @(negedge clk);
        apply_bkt_i = 1'b0;
        wait_done(3);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        @(posedge clk);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "pass" : "fail");
        @(negedge clk);
    endtask

    initial begin
        int err_before;
        int r;
        {start_decision_i, load_lvl_en_i, apply_imply_i, apply_analyze_i} = '0;
        {apply_bkt_i, base_lvl_en_i, load_lvl_i, base_lvl_i} = '0;
        imply_wr_i = '0;
        imply_true_i = '0;
        apply_reset();

        err_before = errors;
        compare_state();
        repeat (NV + 2) do_decide();
        report_test(1, "reset state and ordered decisions", err_before);

        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            r = $random(seed);
            repeat (1 + ($unsigned(r) % 3)) do_decide();
            r = $random(seed);
            do_imply(r[NV-1:0] & r[2*NV-1:NV], r[3*NV-1:2*NV]);
            // same values again change nothing
            do_imply(r[NV-1:0] & r[2*NV-1:NV], r[3*NV-1:2*NV]);
            // contradict the lowest assigned variable
            for (int k = NV - 1; k >= 0; k--) begin
                if (model_val[k] != VAL_FREE) begin
                    r = k;
                end
            end
            if (model_val[r[2:0]] != VAL_FREE) begin
                do_imply(NV'(1) << r[2:0], (model_val[r[2:0]] == VAL_TRUE) ? '0 : '1);
            end
            do_analyze_backtrack();
            report_test(2 + t, "imply, conflict, analysis and backtrack", err_before);
        end

        err_before = errors;
        apply_reset();
        r = $random(seed);
        load_lvl_i = {2'b00, r[5:0]};
        load_lvl_en_i = 1'b1;
        @(posedge clk);
        model_cur = load_lvl_i;
        @(negedge clk);
        load_lvl_en_i = 1'b0;
        check_lvl("cur_lvl_o", cur_lvl_o, model_cur);
        do_decide();
        report_test(NUM_TESTS + 2, "level load then decision", err_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
src/sat_pkg.sv
src/decision_unit.sv
src/var_cell.sv
src/conflict_collector.sv
src/state_list.sv
+incdir+dv
dv/tb_state_list.sv

//--- src/conflict_collector.sv
// Conflict reduction, imply-done detection and analysis control.
// done_imply_o is registered; add_learntc_en_o and done_analyze_o follow
// the analysis state directly. bkt_lvl_o is latched on entry to ANA_DONE
// and holds until the next analysis. Without any conflict the backtrack
// level falls back to the base level.

`timescale 1ns/10ps

module conflict_collector #(
    parameter int NUM_VARS  = 8,
    parameter int WIDTH_LVL = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [NUM_VARS-1:0]           implied_i,
    input  logic [NUM_VARS-1:0]           conflict_i,
    input  logic [NUM_VARS*WIDTH_LVL-1:0] var_lvl_i,
    input  logic                          apply_imply_i,
    input  logic                          apply_analyze_i,
    input  logic                          base_lvl_en_i,
    input  logic [WIDTH_LVL-1:0]          base_lvl_i,
    output logic                          find_conflict_o,
    output logic [NUM_VARS-1:0]           conflict_mask_o,
    output logic                          done_imply_o,
    output logic                          add_learntc_en_o,
    output logic                          done_analyze_o,
    output logic [WIDTH_LVL-1:0]          bkt_lvl_o
);

    import sat_pkg::*;

    logic [NUM_VARS-1:0]  implied_prev;
    logic [NUM_VARS-1:0]  conflict_prev;
    logic [WIDTH_LVL-1:0] base_lvl;
    logic [WIDTH_LVL-1:0] max_lvl;
    logic [WIDTH_LVL-1:0] bkt_lvl_d;
    ana_state_t           state_q;
    ana_state_t           state_d;

    assign find_conflict_o = |conflict_i;
    assign conflict_mask_o = conflict_i;

    // previous vectors for stability checks
    always_ff @(posedge clk) begin
        if (!rst) begin
            implied_prev  <= '0;
            conflict_prev <= '0;
        end else begin
            implied_prev  <= implied_i;
            conflict_prev <= conflict_i;
        end
    end

    // imply done once no new implications appear
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_imply_o <= 1'b0;
        end else begin
            done_imply_o <= apply_imply_i && (implied_i == implied_prev || find_conflict_o);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ANA_IDLE: begin
                if (apply_analyze_i) begin
                    state_d = ANA_FIND;
                end
            end
            ANA_FIND: begin
                if (conflict_i == conflict_prev) begin
                    state_d = ANA_ADD;
                end
            end
            ANA_ADD:  state_d = ANA_DONE;
            ANA_DONE: state_d = ANA_WAIT;
            ANA_WAIT: begin
                // controller drops the request when finished
                if (!apply_analyze_i) begin
                    state_d = ANA_IDLE;
                end
            end
            default:  state_d = ANA_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= ANA_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign add_learntc_en_o = (state_q == ANA_ADD);
    assign done_analyze_o   = (state_q == ANA_DONE);

    // highest level among conflicting cells
    always_comb begin
        max_lvl = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (conflict_i[i] && var_lvl_i[i*WIDTH_LVL +: WIDTH_LVL] > max_lvl) begin
                max_lvl = var_lvl_i[i*WIDTH_LVL +: WIDTH_LVL];
            end
        end
    end

    // max - 1, clamped at base
    assign bkt_lvl_d = (max_lvl > base_lvl) ? max_lvl - 1'b1 : base_lvl;

    always_ff @(posedge clk) begin
        if (!rst) begin
            base_lvl  <= '0;
            bkt_lvl_o <= '0;
        end else begin
            if (base_lvl_en_i) begin
                base_lvl <= base_lvl_i;
            end
            if (state_q == ANA_ADD) begin
                bkt_lvl_o <= bkt_lvl_d;
            end
        end
    end

    // conflict set must hold while the backtrack level is latched
    a_conflict_stable_add: assert property (
        @(posedge clk) disable iff (!rst)
        add_learntc_en_o |-> conflict_i == conflict_prev
    );

endmodule

//--- src/decision_unit.sv
// Current decision level and lowest-free-variable decision.
// start_decision_i is sampled at a clock edge; the strobe to the cells is
// combinational in that same cycle. Backtrack wins over level load,
// which wins over a decision. No free variable: done still pulses.

`timescale 1ns/10ps

module decision_unit #(
    parameter int NUM_VARS  = 8,
    parameter int WIDTH_LVL = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_decision_i,
    input  logic                                 load_lvl_en_i,
    input  logic [WIDTH_LVL-1:0]                 load_lvl_i,
    input  logic                                 apply_bkt_i,
    input  logic [WIDTH_LVL-1:0]                 bkt_lvl_i,
    input  sat_pkg::val_t [NUM_VARS-1:0]         var_value_i,
    output logic [NUM_VARS-1:0]                  decide_onehot_o,
    output logic [WIDTH_LVL-1:0]                 cur_lvl_o,
    output logic                                 done_decision_o
);

    import sat_pkg::*;

    logic [NUM_VARS-1:0] free_onehot;
    logic                found_free;
    logic                decide_go;

    // priority encode, lowest index first
    always_comb begin
        free_onehot = '0;
        found_free  = 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (!found_free && var_value_i[i] == VAL_FREE) begin
                free_onehot[i] = 1'b1;
                found_free     = 1'b1;
            end
        end
    end

    // level updates from backtrack or load take the cycle
    assign decide_go       = start_decision_i && !apply_bkt_i && !load_lvl_en_i;
    assign decide_onehot_o = decide_go ? free_onehot : '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cur_lvl_o <= '0;
        end else if (apply_bkt_i) begin
            cur_lvl_o <= bkt_lvl_i;
        end else if (load_lvl_en_i) begin
            cur_lvl_o <= load_lvl_i;
        end else if (decide_go && found_free) begin
            // new level, same edge as the cell write
            cur_lvl_o <= cur_lvl_o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_decision_o <= 1'b0;
        end else begin
            done_decision_o <= start_decision_i;
        end
    end

    // a decision at the top level would wrap to level 0
    a_decide_no_wrap: assert property (
        @(posedge clk) disable iff (!rst)
        (decide_go && found_free) |-> cur_lvl_o != '1
    );

endmodule

//--- src/sat_pkg.sv
// Shared types of the SAT engine state keeper.
// Value encoding is 2 bits per variable; 2'b11 is never stored.
// The analysis state type serves the conflict analysis control only.

package sat_pkg;

    // variable assignment
    typedef enum logic [1:0] {
        VAL_FREE  = 2'b00,
        VAL_TRUE  = 2'b01,
        VAL_FALSE = 2'b10
    } val_t;

    // conflict analysis control
    typedef enum logic [2:0] {
        ANA_IDLE = 3'd0,
        ANA_FIND = 3'd1,
        ANA_ADD  = 3'd2,
        ANA_DONE = 3'd3,
        ANA_WAIT = 3'd4
    } ana_state_t;

endpackage

//--- src/state_list.sv
// Variable and level state keeper of the SAT engine.
// One var_cell per variable; a backtrack completes in one cycle and
// done_bkt_o follows apply_bkt_i by one cycle. Requests are levels or
// pulses, with no back-pressure. Levels leave as a flat vector,
// variable k in bits [k*WIDTH_LVL +: WIDTH_LVL].

`timescale 1ns/10ps

module state_list #(
    parameter int NUM_VARS  = 8,
    parameter int WIDTH_LVL = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_decision_i,
    input  logic                          load_lvl_en_i,
    input  logic [WIDTH_LVL-1:0]          load_lvl_i,
    input  logic [NUM_VARS-1:0]           imply_wr_i,
    input  logic [NUM_VARS-1:0]           imply_true_i,
    input  logic                          apply_imply_i,
    input  logic                          apply_analyze_i,
    input  logic                          apply_bkt_i,
    input  logic                          base_lvl_en_i,
    input  logic [WIDTH_LVL-1:0]          base_lvl_i,
    output sat_pkg::val_t [NUM_VARS-1:0]  var_value_o,
    output logic [NUM_VARS*WIDTH_LVL-1:0] var_lvl_o,
    output logic [WIDTH_LVL-1:0]          cur_lvl_o,
    output logic                          done_decision_o,
    output logic                          done_imply_o,
    output logic                          find_conflict_o,
    output logic [NUM_VARS-1:0]           conflict_mask_o,
    output logic                          add_learntc_en_o,
    output logic                          done_analyze_o,
    output logic [WIDTH_LVL-1:0]          bkt_lvl_o,
    output logic                          done_bkt_o
);

    logic [NUM_VARS-1:0] decide_onehot;
    logic [NUM_VARS-1:0] implied;
    logic [NUM_VARS-1:0] conflict;

    decision_unit #(
        .NUM_VARS  (NUM_VARS),
        .WIDTH_LVL (WIDTH_LVL)
    ) decision_unit_inst (
        .clk              (clk),
        .rst              (rst),
        .start_decision_i (start_decision_i),
        .load_lvl_en_i    (load_lvl_en_i),
        .load_lvl_i       (load_lvl_i),
        .apply_bkt_i      (apply_bkt_i),
        .bkt_lvl_i        (bkt_lvl_o),
        .var_value_i      (var_value_o),
        .decide_onehot_o  (decide_onehot),
        .cur_lvl_o        (cur_lvl_o),
        .done_decision_o  (done_decision_o)
    );

    for (genvar k = 0; k < NUM_VARS; k++) begin : g_cell
        var_cell #(
            .WIDTH_LVL (WIDTH_LVL)
        ) var_cell_inst (
            .clk          (clk),
            .rst          (rst),
            .decide_i     (decide_onehot[k]),
            .cur_lvl_i    (cur_lvl_o),
            .imply_wr_i   (imply_wr_i[k]),
            .imply_true_i (imply_true_i[k]),
            .apply_bkt_i  (apply_bkt_i),
            .bkt_lvl_i    (bkt_lvl_o),
            .value_o      (var_value_o[k]),
            .lvl_o        (var_lvl_o[k*WIDTH_LVL +: WIDTH_LVL]),
            .implied_o    (implied[k]),
            .conflict_o   (conflict[k])
        );
    end

    conflict_collector #(
        .NUM_VARS  (NUM_VARS),
        .WIDTH_LVL (WIDTH_LVL)
    ) conflict_collector_inst (
        .clk              (clk),
        .rst              (rst),
        .implied_i        (implied),
        .conflict_i       (conflict),
        .var_lvl_i        (var_lvl_o),
        .apply_imply_i    (apply_imply_i),
        .apply_analyze_i  (apply_analyze_i),
        .base_lvl_en_i    (base_lvl_en_i),
        .base_lvl_i       (base_lvl_i),
        .find_conflict_o  (find_conflict_o),
        .conflict_mask_o  (conflict_mask_o),
        .done_imply_o     (done_imply_o),
        .add_learntc_en_o (add_learntc_en_o),
        .done_analyze_o   (done_analyze_o),
        .bkt_lvl_o        (bkt_lvl_o)
    );

    // backtrack finishes in the cycle it is applied
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_bkt_o <= 1'b0;
        end else begin
            done_bkt_o <= apply_bkt_i;
        end
    end

endmodule

//--- src/var_cell.sv
// State cell of one variable: value, level, implied mark, conflict flag.
// A decision writes VAL_FALSE at cur_lvl_i + 1; an imply write uses cur_lvl_i.
// A contradicting imply write only raises the conflict flag.
// Backtrack frees the cell if its level is above bkt_lvl_i.

`timescale 1ns/10ps

module var_cell #(
    parameter int WIDTH_LVL = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 decide_i,
    input  logic [WIDTH_LVL-1:0] cur_lvl_i,
    input  logic                 imply_wr_i,
    input  logic                 imply_true_i,
    input  logic                 apply_bkt_i,
    input  logic [WIDTH_LVL-1:0] bkt_lvl_i,
    output sat_pkg::val_t        value_o,
    output logic [WIDTH_LVL-1:0] lvl_o,
    output logic                 implied_o,
    output logic                 conflict_o
);

    import sat_pkg::*;

    val_t imply_val;

    assign imply_val = imply_true_i ? VAL_TRUE : VAL_FALSE;

    always_ff @(posedge clk) begin
        if (!rst) begin
            value_o    <= VAL_FREE;
            lvl_o      <= '0;
            implied_o  <= 1'b0;
            conflict_o <= 1'b0;
        end else if (apply_bkt_i) begin
            conflict_o <= 1'b0;
            if (lvl_o > bkt_lvl_i) begin
                value_o   <= VAL_FREE;
                lvl_o     <= '0;
                implied_o <= 1'b0;
            end
        end else if (decide_i) begin
            value_o   <= VAL_FALSE;
            lvl_o     <= cur_lvl_i + 1'b1;
            implied_o <= 1'b0;
        end else if (imply_wr_i) begin
            if (value_o == VAL_FREE) begin
                value_o   <= imply_val;
                lvl_o     <= cur_lvl_i;
                implied_o <= 1'b1;
            end else if (value_o != imply_val) begin
                // value kept, analysis decides what to do
                conflict_o <= 1'b1;
            end
        end
    end

    // a decision would hide an imply write in the same cycle
    a_decide_no_imply: assert property (
        @(posedge clk) disable iff (!rst)
        decide_i |-> !imply_wr_i
    );

    // decision unit must only pick free cells
    a_decide_free: assert property (
        @(posedge clk) disable iff (!rst)
        decide_i |-> value_o == VAL_FREE
    );

endmodule
